// ==== mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// block RAM geometry
`define RAM_WORDS   256
`define RAM_IDX_W   8

// region bases
`define RAM_BASE    32'h0000_0000
`define TIMER_BASE  32'h4000_0000

// timer register byte offsets from TIMER_BASE
`define MTIME_LO_OFS     0   // read only
`define MTIME_HI_OFS     4   // read only
`define MTIMECMP_LO_OFS  8
`define MTIMECMP_HI_OFS  12

// address driven when nothing is issued
`define ADDR_NOP    32'hffff_ffff

// inst/rdata when not valid, also unmapped read value
`define DATA_NONE   32'hffff_ffff

`endif

// ==== bus_pkg.sv ====
package bus_pkg;

    // data port command from the core
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] wmask;   // 1 = take new bit
    } data_req_t;

    // merged command, arbiter to map controller
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] wmask;
    } mem_cmd_t;

    typedef enum logic [1:0] {
        wait_cmd,
        wait_ready,
        wait_read
    } arb_state_e;

endpackage

// ==== map_pkg.sv ====
package map_pkg;

    // where a word address lands
    typedef enum logic [1:0] {
        region_ram,
        region_timer,
        region_unmapped
    } region_e;

    // decoded target, index is the word offset inside the region
    typedef struct packed {
        region_e     region;
        logic [31:0] index;
    } map_target_t;

endpackage

// ==== main_ram.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module main_ram (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  en,
    input  logic                  we,
    input  logic [`RAM_IDX_W-1:0] index,
    input  logic [31:0]           wdata,
    input  logic [31:0]           wmask,
    output logic [31:0]           rdata,
    output logic                  busy
);

    logic [31:0]           mem [`RAM_WORDS];
    logic [`RAM_IDX_W-1:0] clr_idx;   // clear sweep pointer

    // one word cleared per cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b1;
            clr_idx <= '0;
        end else if (busy) begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == `RAM_IDX_W'(`RAM_WORDS - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            mem[clr_idx] <= '0;
        end else if (en && we) begin
            mem[index] <= (mem[index] & ~wmask) | (wdata & wmask);  // bit merge
        end
        if (en) begin
            rdata <= mem[index];   // old word on a write
        end
    end

endmodule

// ==== mem_map_ctrl.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_map_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  bus_pkg::mem_cmd_t     cmd,
    output logic                  ready,
    output logic [31:0]           rdata,
    output logic                  rdata_valid,
    input  logic [63:0]           mtime,
    output logic [63:0]           mtimecmp,
    output logic                  ram_en,
    output logic                  ram_we,
    output logic [`RAM_IDX_W-1:0] ram_index,
    output logic [31:0]           ram_wdata,
    output logic [31:0]           ram_wmask,
    input  logic [31:0]           ram_rdata,
    input  logic                  ram_busy
);
    import map_pkg::*;

    map_target_t tgt;
    logic [31:0] ram_ofs;
    logic [31:0] tmr_ofs;
    logic        accept;
    logic [31:0] tmr_word;
    logic        busy_q;      // one-cycle service stage
    logic        read_q;
    region_e     region_q;
    logic [31:0] tmr_rdata;

    assign ram_ofs = cmd.addr - `RAM_BASE;
    assign tmr_ofs = cmd.addr - `TIMER_BASE;

    // low two address bits dropped
    always_comb begin
        if (ram_ofs < `RAM_WORDS * 4) begin
            tgt.region = region_ram;
            tgt.index  = {2'b00, ram_ofs[31:2]};
        end else if (tmr_ofs < `MTIMECMP_HI_OFS + 4) begin
            tgt.region = region_timer;
            tgt.index  = {2'b00, tmr_ofs[31:2]};
        end else begin
            tgt.region = region_unmapped;
            tgt.index  = '0;
        end
    end

    assign ready  = !busy_q && !ram_busy;
    assign accept = start && ready;

    assign ram_en    = accept && (tgt.region == region_ram);
    assign ram_we    = cmd.write;
    assign ram_index = tgt.index[`RAM_IDX_W-1:0];
    assign ram_wdata = cmd.wdata;
    assign ram_wmask = cmd.wmask;

    always_comb begin
        case (tgt.index[1:0])
            2'(`MTIME_LO_OFS >> 2):    tmr_word = mtime[31:0];
            2'(`MTIME_HI_OFS >> 2):    tmr_word = mtime[63:32];
            2'(`MTIMECMP_LO_OFS >> 2): tmr_word = mtimecmp[31:0];
            default:                   tmr_word = mtimecmp[63:32];
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q   <= 1'b0;
            read_q   <= 1'b0;
            region_q <= region_unmapped;
            mtimecmp <= '1;
        end else begin
            busy_q <= accept;
            if (accept) begin
                read_q   <= !cmd.write;
                region_q <= tgt.region;
            end
            if (accept && cmd.write && tgt.region == region_timer) begin
                // mtime halves are read only
                if (tgt.index[1:0] == 2'(`MTIMECMP_LO_OFS >> 2)) begin
                    mtimecmp[31:0] <= (mtimecmp[31:0] & ~cmd.wmask) | (cmd.wdata & cmd.wmask);
                end else if (tgt.index[1:0] == 2'(`MTIMECMP_HI_OFS >> 2)) begin
                    mtimecmp[63:32] <= (mtimecmp[63:32] & ~cmd.wmask)
                                     | (cmd.wdata & cmd.wmask);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tmr_rdata <= tmr_word;   // sampled at accept
        end
    end

    assign rdata_valid = busy_q && read_q;

    always_comb begin
        if (!rdata_valid) begin
            rdata = `DATA_NONE;
        end else begin
            case (region_q)
                region_ram:   rdata = ram_rdata;
                region_timer: rdata = tmr_rdata;
                default:      rdata = `DATA_NONE;
            endcase
        end
    end

    a_no_valid_after_write: assert property (@(posedge clk) disable iff (rst)
        (start && ready && cmd.write) |=> !rdata_valid);

endmodule

// ==== mem_arbiter.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  logic               halt,
    input  logic               fetch_start,
    output logic               fetch_ready,
    input  logic [31:0]        fetch_addr,
    output logic [31:0]        inst,
    output logic               inst_valid,
    input  logic               data_start,
    output logic               data_ready,
    input  bus_pkg::data_req_t data_req,
    output logic [31:0]        rdata,
    output logic               rdata_valid,
    output logic               mem_start,
    output bus_pkg::mem_cmd_t  mem_cmd,
    input  logic               mem_ready,
    input  logic [31:0]        mem_rdata,
    input  logic               mem_rdata_valid
);
    import bus_pkg::*;

    arb_state_e  state;
    logic        cmd_is_inst;    // fetch is the one in flight
    logic        save_d_start;   // data command waits behind the fetch
    logic [31:0] save_i_addr;
    data_req_t   save_d;
    logic        res_pend;       // result arrived during halt
    logic [31:0] res_data;
    logic        res_valid;
    logic [31:0] res_word;
    mem_cmd_t    cmd_sel;

    assign fetch_ready = (state == wait_cmd);
    assign data_ready  = (state == wait_cmd);

    assign res_valid = mem_rdata_valid || res_pend;
    assign res_word  = res_pend ? res_data : mem_rdata;

    always_comb begin
        case (state)
            wait_cmd:   mem_start = !halt && mem_ready && (fetch_start || data_start);
            wait_ready: mem_start = !halt && mem_ready;
            default:    mem_start = 1'b0;
        endcase
    end

    // fetch wins when both start together
    always_comb begin
        if (state == wait_cmd) begin
            cmd_sel = mem_cmd_t'(data_req);
            if (fetch_start) begin
                cmd_sel.write = 1'b0;
                cmd_sel.addr  = fetch_addr;
            end
        end else begin
            cmd_sel = mem_cmd_t'(save_d);
            if (cmd_is_inst) begin
                cmd_sel.write = 1'b0;
                cmd_sel.addr  = save_i_addr;
            end
        end
    end

    always_comb begin
        mem_cmd = cmd_sel;
        if (!mem_start) begin
            mem_cmd.write = 1'b0;
            mem_cmd.addr  = `ADDR_NOP;
        end
    end

    assign inst_valid  = !halt && (state == wait_read) && res_valid && cmd_is_inst;
    assign rdata_valid = !halt && (state == wait_read) && res_valid && !cmd_is_inst;
    assign inst        = inst_valid ? res_word : `DATA_NONE;
    assign rdata       = rdata_valid ? res_word : `DATA_NONE;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= wait_cmd;
            cmd_is_inst  <= 1'b0;
            save_d_start <= 1'b0;
            res_pend     <= 1'b0;
        end else if (halt) begin
            // state frozen, but keep a result that lands now
            if (state == wait_read && mem_rdata_valid) begin
                res_pend <= 1'b1;
            end
        end else begin
            case (state)
                wait_cmd: begin
                    if (fetch_start || data_start) begin
                        cmd_is_inst  <= fetch_start;
                        save_d_start <= data_start;
                        if (!mem_ready) begin
                            state <= wait_ready;
                        end else if (fetch_start || !data_req.write) begin
                            state <= wait_read;
                        end
                        // data write issued, stay in wait_cmd
                    end
                end
                wait_ready: begin
                    if (mem_ready) begin
                        if (cmd_is_inst || !save_d.write) begin
                            state <= wait_read;
                        end else begin
                            state <= wait_cmd;
                        end
                    end
                end
                wait_read: begin
                    if (res_valid) begin
                        res_pend <= 1'b0;
                        if (cmd_is_inst && save_d_start) begin
                            cmd_is_inst <= 1'b0;   // chain the data command
                            state       <= wait_ready;
                        end else begin
                            state <= wait_cmd;
                        end
                    end
                end
                default: state <= wait_cmd;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!halt && state == wait_cmd) begin
            save_i_addr <= fetch_addr;
            save_d      <= data_req;
        end
        if (halt && state == wait_read && mem_rdata_valid) begin
            res_data <= mem_rdata;
        end
    end

    a_one_valid: assert property (@(posedge clk) disable iff (rst)
        !(inst_valid && rdata_valid));

    a_start_needs_ready: assert property (@(posedge clk) disable iff (rst)
        mem_start |-> mem_ready);

endmodule

// ==== mem_subsys_top.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_subsys_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               halt,
    input  logic               fetch_start,
    output logic               fetch_ready,
    input  logic [31:0]        fetch_addr,
    output logic [31:0]        inst,
    output logic               inst_valid,
    input  logic               data_start,
    output logic               data_ready,
    input  bus_pkg::data_req_t data_req,
    output logic [31:0]        rdata,
    output logic               rdata_valid,
    input  logic [63:0]        mtime,
    output logic [63:0]        mtimecmp
);
    import bus_pkg::*;

    logic                  mem_start;
    mem_cmd_t              mem_cmd;
    logic                  mem_ready;
    logic [31:0]           mem_rdata;
    logic                  mem_rdata_valid;
    logic                  ram_en;
    logic                  ram_we;
    logic [`RAM_IDX_W-1:0] ram_index;
    logic [31:0]           ram_wdata;
    logic [31:0]           ram_wmask;
    logic [31:0]           ram_rdata;
    logic                  ram_busy;

    mem_arbiter u_arb (
        .clk(clk), .rst(rst), .halt(halt),
        .fetch_start(fetch_start), .fetch_ready(fetch_ready), .fetch_addr(fetch_addr),
        .inst(inst), .inst_valid(inst_valid),
        .data_start(data_start), .data_ready(data_ready), .data_req(data_req),
        .rdata(rdata), .rdata_valid(rdata_valid),
        .mem_start(mem_start), .mem_cmd(mem_cmd), .mem_ready(mem_ready),
        .mem_rdata(mem_rdata), .mem_rdata_valid(mem_rdata_valid)
    );

    mem_map_ctrl u_map (
        .clk(clk), .rst(rst), .start(mem_start), .cmd(mem_cmd),
        .ready(mem_ready), .rdata(mem_rdata), .rdata_valid(mem_rdata_valid),
        .mtime(mtime), .mtimecmp(mtimecmp),
        .ram_en(ram_en), .ram_we(ram_we), .ram_index(ram_index),
        .ram_wdata(ram_wdata), .ram_wmask(ram_wmask),
        .ram_rdata(ram_rdata), .ram_busy(ram_busy)
    );

    main_ram u_ram (
        .clk(clk), .rst(rst), .en(ram_en), .we(ram_we), .index(ram_index),
        .wdata(ram_wdata), .wmask(ram_wmask), .rdata(ram_rdata), .busy(ram_busy)
    );

endmodule

// ==== tb_mem_subsys.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module tb_mem_subsys;
    import bus_pkg::*;

    // port operations per test, summed over all tests
    localparam int N_OPS = 1 + 6 * 4 + 4 * 3 + 8 + 5 + 2;

    logic        clk;
    logic        rst;
    logic        halt;
    logic        fetch_start;
    logic        fetch_ready;
    logic [31:0] fetch_addr;
    logic [31:0] inst;
    logic        inst_valid;
    logic        data_start;
    logic        data_ready;
    data_req_t   data_req;
    logic [31:0] rdata;
    logic        rdata_valid;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;

    logic [31:0] model_mem [`RAM_WORDS];
    logic [63:0] model_cmp;
    logic [31:0] exp_inst_q [$];
    logic [31:0] exp_rdata_q [$];
    logic [31:0] lfsr;
    int          cyc;
    int          i_start;
    int          d_start;
    int          i_lat;
    int          d_lat;
    int          n_inst;
    int          n_rdata;
    int          errors;
    int          n_tests;
    int          n_failed;

    mem_subsys_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // expected read value from the memory map rules
    function automatic logic [31:0] expect_read(input logic [31:0] addr);
        logic [31:0] rofs;
        logic [31:0] tofs;
        rofs = addr - `RAM_BASE;
        tofs = addr - `TIMER_BASE;
        if (rofs < `RAM_WORDS * 4) begin
            return model_mem[rofs[`RAM_IDX_W+1:2]];
        end
        if (tofs < `MTIMECMP_HI_OFS + 4) begin
            case ({tofs[3:2], 2'b00})
                `MTIME_LO_OFS:    return mtime[31:0];
                `MTIME_HI_OFS:    return mtime[63:32];
                `MTIMECMP_LO_OFS: return model_cmp[31:0];
                default:          return model_cmp[63:32];
            endcase
        end
        return `DATA_NONE;   // unmapped
    endfunction

    function automatic void model_write(input logic [31:0] addr, input logic [31:0] wdata,
                                        input logic [31:0] wmask);
        logic [31:0] rofs;
        logic [31:0] wofs;
        rofs = addr - `RAM_BASE;
        wofs = (addr - `TIMER_BASE) & ~32'd3;
        if (rofs < `RAM_WORDS * 4) begin
            model_mem[rofs[`RAM_IDX_W+1:2]] = (model_mem[rofs[`RAM_IDX_W+1:2]] & ~wmask)
                                            | (wdata & wmask);
        end else if (wofs == `MTIMECMP_LO_OFS) begin
            model_cmp[31:0] = (model_cmp[31:0] & ~wmask) | (wdata & wmask);
        end else if (wofs == `MTIMECMP_HI_OFS) begin
            model_cmp[63:32] = (model_cmp[63:32] & ~wmask) | (wdata & wmask);
        end
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            errors++;
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic check_lat(input string name, input int lat);
        assert (lat == 1) else begin
            errors++;
            $display("** Error at %0t: %s latency expected 1, got %0d", $time, name, lat);
        end
    endtask

    // one port operation where fetch and data may start together
    task automatic run_op(input logic do_f, input logic [31:0] f_addr, input logic do_d,
                          input logic d_wr, input logic [31:0] d_addr,
                          input logic [31:0] d_wdata, input logic [31:0] d_wmask);
        int ni;
        int nr;
        ni = n_inst;
        nr = n_rdata;
        while (!(fetch_ready && data_ready)) @(negedge clk);
        fetch_start    = do_f;
        fetch_addr     = f_addr;
        data_start     = do_d;
        data_req.write = d_wr;
        data_req.addr  = d_addr;
        data_req.wdata = d_wdata;
        data_req.wmask = d_wmask;
        if (do_f) exp_inst_q.push_back(expect_read(f_addr));   // fetch is served first
        if (do_d && d_wr) model_write(d_addr, d_wdata, d_wmask);
        if (do_d && !d_wr) exp_rdata_q.push_back(expect_read(d_addr));
        @(negedge clk);
        fetch_start = 1'b0;
        data_start  = 1'b0;
        if (do_f) begin
            while (n_inst == ni) @(negedge clk);
            assert (!(do_d && !d_wr) || n_rdata == nr) else begin
                errors++;
                $display("data result at %0t arrived before the fetch result", $time);
            end
        end
        if (do_d && !d_wr) begin
            while (n_rdata == nr) @(negedge clk);
        end
        while (!(fetch_ready && data_ready)) @(negedge clk);
        if (do_d && d_wr) @(negedge clk);   // let the write stage drain
    endtask

    task automatic end_test(input string name, input int err_before);
        n_tests++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            n_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - err_before);
        end
    endtask

    // compares every result pulse against the queued expectation
    always @(posedge clk) begin
        logic [31:0] exp_word;
        cyc = cyc + 1;
        if (!rst) begin
            if (fetch_start && fetch_ready && !halt) i_start = cyc;
            if (data_start && data_ready && !halt) d_start = cyc;
            if (inst_valid) begin
                assert (exp_inst_q.size() > 0) else begin
                    errors++;
                    $display("unexpected inst_valid pulse at %0t, no fetch outstanding", $time);
                end
                if (exp_inst_q.size() > 0) begin
                    exp_word = exp_inst_q.pop_front();
                    check_val("inst", exp_word, inst);
                end
                i_lat = cyc - i_start;
                n_inst++;
            end
            if (rdata_valid) begin
                assert (exp_rdata_q.size() > 0) else begin
                    errors++;
                    $display("unexpected rdata_valid pulse at %0t, no read outstanding", $time);
                end
                if (exp_rdata_q.size() > 0) begin
                    exp_word = exp_rdata_q.pop_front();
                    check_val("rdata", exp_word, rdata);
                end
                d_lat = cyc - d_start;
                n_rdata++;
            end
        end
    end

    // the sweep adds RAM_WORDS cycles on top of the operations
    initial begin
        repeat (N_OPS * 10 + `RAM_WORDS) @(posedge clk);
        $display("watchdog timeout at %0t, a result or ready never came back", $time);
        $display("sim failed");
        $finish;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] wd;
        logic [31:0] wm;
        int          e0;
        int          ni;
        int          nr;
        rst         = 1'b1;
        halt        = 1'b0;
        fetch_start = 1'b0;
        fetch_addr  = '0;
        data_start  = 1'b0;
        data_req    = '0;
        mtime       = '0;
        model_cmp   = '1;
        lfsr        = 32'd9;
        cyc         = 0;
        errors      = 0;
        n_tests     = 0;
        n_failed    = 0;
        n_inst      = 0;
        n_rdata     = 0;
        foreach (model_mem[i]) model_mem[i] = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        e0 = errors;
        check_val("fetch_ready", 1, fetch_ready);
        check_val("data_ready", 1, data_ready);
        run_op(1, rand_bits(10), 0, 0, 0, 0, 0);   // completes once the sweep is over
        end_test("reset and clear sweep", e0);

        e0 = errors;
        repeat (6) begin
            a  = rand_bits(10);
            b  = rand_bits(32);
            wd = rand_bits(32);
            wm = rand_bits(32);
            run_op(0, 0, 1, 1, a, b, '1);
            run_op(0, 0, 1, 1, a, wd, wm);
            run_op(1, a, 0, 0, 0, 0, 0);
            check_lat("inst_valid", i_lat);
            run_op(0, 0, 1, 0, a ^ rand_bits(2), 0, 0);   // low bits ignored
            check_lat("rdata_valid", d_lat);
        end
        end_test("masked write and read", e0);

        e0 = errors;
        repeat (4) begin
            a  = rand_bits(10);
            b  = rand_bits(10);
            wd = rand_bits(32);
            wm = rand_bits(32);
            run_op(1, a, 1, 0, b, 0, 0);
            run_op(1, b, 1, 1, a, wd, wm);   // write chained behind the fetch
            run_op(1, b, 1, 0, a, 0, 0);
        end
        end_test("fetch and data together", e0);

        e0 = errors;
        check_val("mtimecmp", '1, mtimecmp);
        mtime = {rand_bits(32), rand_bits(32)};
        run_op(0, 0, 1, 0, `TIMER_BASE + `MTIME_LO_OFS, 0, 0);
        run_op(1, `TIMER_BASE + `MTIME_HI_OFS, 0, 0, 0, 0, 0);
        run_op(0, 0, 1, 1, `TIMER_BASE + `MTIME_LO_OFS, rand_bits(32), '1);
        run_op(0, 0, 1, 0, `TIMER_BASE + `MTIME_LO_OFS, 0, 0);
        wd = rand_bits(32);
        wm = rand_bits(32);
        run_op(0, 0, 1, 1, `TIMER_BASE + `MTIMECMP_LO_OFS, wd, wm);
        wd = rand_bits(32);
        wm = rand_bits(32);
        run_op(0, 0, 1, 1, `TIMER_BASE + `MTIMECMP_HI_OFS, wd, wm);
        check_val("mtimecmp", model_cmp, mtimecmp);
        run_op(0, 0, 1, 0, `TIMER_BASE + `MTIMECMP_LO_OFS, 0, 0);
        run_op(1, `TIMER_BASE + `MTIMECMP_HI_OFS, 0, 0, 0, 0, 0);
        end_test("timer registers", e0);

        e0 = errors;
        run_op(0, 0, 1, 0, 32'h2000_0000, 0, 0);
        run_op(1, `TIMER_BASE + 32'h10, 0, 0, 0, 0, 0);
        run_op(0, 0, 1, 1, `RAM_WORDS * 4, rand_bits(32), '1);   // would alias word 0
        run_op(0, 0, 1, 1, `TIMER_BASE + 32'h18, rand_bits(32), '1);   // would alias mtimecmp low
        run_op(1, `RAM_BASE, 0, 0, 0, 0, 0);
        check_val("mtimecmp", model_cmp, mtimecmp);
        end_test("unmapped access", e0);

        e0 = errors;
        ni = n_inst;
        nr = n_rdata;
        halt           = 1'b1;
        fetch_start    = 1'b1;
        fetch_addr     = rand_bits(10);
        data_start     = 1'b1;
        data_req.write = 1'b0;
        data_req.addr  = rand_bits(10);
        @(negedge clk);
        fetch_start = 1'b0;
        data_start  = 1'b0;
        repeat (3) @(negedge clk);
        halt = 1'b0;
        repeat (4) @(negedge clk);
        assert (n_inst == ni && n_rdata == nr) else begin
            errors++;
            $display("a start given during halt produced a result pulse");
        end
        a = rand_bits(10);
        exp_inst_q.push_back(expect_read(a));
        fetch_start = 1'b1;
        fetch_addr  = a;
        @(negedge clk);
        fetch_start = 1'b0;
        halt        = 1'b1;   // result lands while frozen
        repeat (4) @(negedge clk);
        assert (n_inst == ni) else begin
            errors++;
            $display("inst_valid pulsed while halt was high");
        end
        halt = 1'b0;
        while (n_inst == ni) @(negedge clk);
        end_test("halt", e0);

        assert (exp_inst_q.size() == 0 && exp_rdata_q.size() == 0) else begin
            errors++;
            $display("%0d fetch and %0d data results never arrived",
                     exp_inst_q.size(), exp_rdata_q.size());
        end
        $display("%0d tests, %0d failed, %0d errors, %0d inst and %0d rdata results checked",
                 n_tests, n_failed, errors, n_inst, n_rdata);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+.
bus_pkg.sv
map_pkg.sv
main_ram.sv
mem_map_ctrl.sv
mem_arbiter.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f tb.f --top-module tb_mem_subsys -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# verdict comes from the log
if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
